/* verilog.f */
+incdir+verilog
verilog/i3c_csr_pkg.sv
verilog/cpuif_axi_lite.sv
verilog/csr_regs.sv
verilog/data_port_queue.sv
verilog/cpuif_mux.sv
verilog/i3c_csr_top.sv
bench/i3c_csr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the I3C CSR testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f verilog.f --top-module i3c_csr_tb \
    -Mdir obj_dir -o i3c_csr_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/i3c_csr_sim 2>&1 | tee "$LOG"

grep -qx "Test passed" "$LOG" \
  && { echo "Simulation PASS"; exit 0; } \
  || { echo "Simulation FAIL"; exit 1; }

/* bench/csr_input.txt */
# op: 0 read, 1 write, 2 check ctrl_o, 3 check irq_o
# columns in hex: op addr wdata wstrb expected_data expected_resp
0 00 00000000 0 00000120 0
1 00 FFFFFFFF F 00000000 2
0 00 00000000 0 00000120 0
1 14 11223344 F 00000000 0
1 14 AABBCCDD 5 00000000 0
0 14 00000000 0 11BB33DD 0
1 08 80550000 C 00000000 0
1 08 FFFFFFFF 1 00000000 0
0 08 00000000 0 80550000 0
1 04 00000003 1 00000000 0
2 00 00000000 0 000003D5 0
0 04 00000000 0 00000003 0
1 0C 00000001 1 00000000 0
2 00 00000000 0 00000000 0
0 0C 00000000 0 00000000 0
0 14 00000000 0 00000000 0
0 04 00000000 0 00000000 0
0 28 00000000 0 00000100 0
0 24 00000000 0 00000000 2
1 10 00000004 1 00000000 0
1 20 A0000000 F 00000000 0
1 20 A0000001 F 00000000 0
1 20 A0000002 F 00000000 0
3 00 00000000 0 00000000 0
1 20 A0000003 F 00000000 0
3 00 00000000 0 00000001 0
1 20 A0000004 F 00000000 0
1 20 A0000005 F 00000000 0
1 20 A0000006 F 00000000 0
1 20 A0000007 F 00000000 0
0 28 00000000 0 00000608 0
1 20 DEADBEEF F 00000000 2
0 24 00000000 0 A0000000 0
0 24 00000000 0 A0000001 0
0 28 00000000 0 00000406 0
1 0C 00000010 1 00000000 0
3 00 00000000 0 00000000 0
0 28 00000000 0 00000100 0
1 20 12345678 1 00000000 0
1 20 9ABCDEF0 F 00000000 0
0 28 00000000 0 00000002 0
0 24 00000000 0 12345678 0
0 24 00000000 0 9ABCDEF0 0
0 24 00000000 0 00000000 2
0 3C 00000000 0 00000000 2
1 FC 12345678 F 00000000 2
0 20 00000000 0 00000000 2
1 28 00000001 F 00000000 2
1 24 00000001 F 00000000 2
0 00 00000000 0 00000120 0

/* bench/i3c_csr_tb.sv */
// Testbench for the I3C CSR subsystem: clock, reset, AXI4-Lite driver,
// file-driven transaction sequence, compare tasks and watchdog
`default_nettype none

`include "i3c_csr_macros.svh"

module i3c_csr_tb
  import i3c_csr_pkg::*;
;

  typedef struct {
    logic [3:0]             op;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_DATA_W-1:0] data;
    logic [3:0]             strb;
    logic [`CSR_DATA_W-1:0] exp_data;
    logic [1:0]             exp_resp;
    int                     line_no;
  } vector_t;

  logic                       clk_i;
  logic                       rst_i;
  logic [`CSR_ADDR_W-1:0]     awaddr_i;
  logic                       awvalid_i;
  logic                       awready_o;
  logic [`CSR_DATA_W-1:0]     wdata_i;
  logic [`CSR_DATA_W/8-1:0]   wstrb_i;
  logic                       wvalid_i;
  logic                       wready_o;
  logic [1:0]                 bresp_o;
  logic                       bvalid_o;
  logic                       bready_i;
  logic [`CSR_ADDR_W-1:0]     araddr_i;
  logic                       arvalid_i;
  logic                       arready_o;
  logic [`CSR_DATA_W-1:0]     rdata_o;
  logic [1:0]                 rresp_o;
  logic                       rvalid_o;
  logic                       rready_i;
  hc_ctrl_t                   ctrl_o;
  logic                       irq_o;

  vector_t vec_q[$];
  integer  seed;
  int      errors;
  int      checks;
  logic    load_done;

  i3c_csr_top UUT (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .ctrl_o    (ctrl_o),
    .irq_o     (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_resp(input string name, input axi_resp_e got,
                            input axi_resp_e exp, input int line_no);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h (input line %0d)",
               name, got, exp, line_no);
    end
  endtask

  task automatic check_data(input string name, input logic [`CSR_DATA_W-1:0] got,
                            input logic [`CSR_DATA_W-1:0] exp, input int line_no);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%08h, expected 0x%08h (input line %0d)",
               name, got, exp, line_no);
    end
  endtask

  task automatic check_ctrl(input string name, input hc_ctrl_t got,
                            input hc_ctrl_t exp, input int line_no);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%03h, expected 0x%03h (input line %0d)",
               name, got, exp, line_no);
    end
  endtask

  task automatic check_irq(input string name, input logic got,
                           input logic exp, input int line_no);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h (input line %0d)",
               name, got, exp, line_no);
    end
  endtask

  // Skips comment and blank lines
  task automatic load_vectors(output logic ok);
    integer      fd;
    int          cnt;
    int          r;
    int          line_cnt;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_strb;
    logic [31:0] f_exp;
    logic [31:0] f_resp;
    vector_t     v;
    ok = 1'b0;
    line_cnt = 0;
    fd = $fopen("bench/csr_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        r = $fgets(line, fd);
        line_cnt++;
        if (r > 0 && line.getc(0) != 8'h23) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h",
                        f_op, f_addr, f_data, f_strb, f_exp, f_resp);
          if (cnt == 6) begin
            v.op       = f_op[3:0];
            v.addr     = f_addr[`CSR_ADDR_W-1:0];
            v.data     = f_data;
            v.strb     = f_strb[3:0];
            v.exp_data = f_exp;
            v.exp_resp = f_resp[1:0];
            v.line_no  = line_cnt;
            vec_q.push_back(v);
          end
        end
      end
      $fclose(fd);
      ok = (vec_q.size() > 0);
    end
  endtask

  task automatic axi_write(input logic [`CSR_ADDR_W-1:0] addr,
                           input logic [`CSR_DATA_W-1:0] data,
                           input logic [3:0] strb, output axi_resp_e resp);
    logic [31:0] rnd;
    logic        done;
    @(posedge clk_i);
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    wdata_i   <= data;
    wstrb_i   <= strb;
    wvalid_i  <= 1'b1;
    @(negedge clk_i);
    while (!(awready_o && wready_o)) @(negedge clk_i);
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    done = 1'b0;
    // Random back-pressure on B
    while (!done) begin
      rnd = $random(seed);
      bready_i <= rnd[0] | rnd[1];
      @(negedge clk_i);
      if (bvalid_o && bready_i) begin
        resp = axi_resp_e'(bresp_o);
        done = 1'b1;
      end
      @(posedge clk_i);
    end
    bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [`CSR_ADDR_W-1:0] addr,
                          output logic [`CSR_DATA_W-1:0] data, output axi_resp_e resp);
    logic [31:0] rnd;
    logic        done;
    @(posedge clk_i);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    @(negedge clk_i);
    while (!arready_o) @(negedge clk_i);
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    done = 1'b0;
    while (!done) begin
      rnd = $random(seed);
      rready_i <= rnd[0] | rnd[1];
      @(negedge clk_i);
      if (rvalid_o && rready_i) begin
        data = rdata_o;
        resp = axi_resp_e'(rresp_o);
        done = 1'b1;
      end
      @(posedge clk_i);
    end
    rready_i <= 1'b0;
  endtask

  // An accepted response must not show up again
  task automatic expect_resp_retired(input int line_no);
    @(negedge clk_i);
    if (bvalid_o || rvalid_o) begin
      errors++;
      $display("Response still valid after it was accepted (input line %0d)", line_no);
    end
  endtask

  task automatic run_vector(input vector_t v);
    logic [`CSR_DATA_W-1:0] rd;
    axi_resp_e              resp;
    case (v.op)
      4'd0: begin
        axi_read(v.addr, rd, resp);
        check_data("rdata_o", rd, v.exp_data, v.line_no);
        check_resp("rresp_o", resp, axi_resp_e'(v.exp_resp), v.line_no);
        expect_resp_retired(v.line_no);
      end
      4'd1: begin
        axi_write(v.addr, v.data, v.strb, resp);
        check_resp("bresp_o", resp, axi_resp_e'(v.exp_resp), v.line_no);
        expect_resp_retired(v.line_no);
      end
      4'd2: begin
        @(negedge clk_i);
        check_ctrl("ctrl_o", ctrl_o, hc_ctrl_t'(v.exp_data[9:0]), v.line_no);
      end
      4'd3: begin
        @(negedge clk_i);
        check_irq("irq_o", irq_o, v.exp_data[0], v.line_no);
      end
      default: begin
        errors++;
        $display("Unknown operation %0d on input line %0d", v.op, v.line_no);
      end
    endcase
  endtask

  initial begin
    logic ok;
    rst_i     = 1'b1;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    seed      = 32'h9e65539d;
    errors    = 0;
    checks    = 0;
    load_done = 1'b0;
    load_vectors(ok);
    load_done = 1'b1;
    if (!ok) begin
      errors++;
      $display("Could not read any transactions from bench/csr_input.txt");
    end else begin
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      if (!arready_o || awready_o || wready_o || bvalid_o || rvalid_o) begin
        errors++;
        $display("AXI handshake outputs are wrong after reset");
      end
      check_ctrl("ctrl_o", ctrl_o, '0, 0);
      check_irq("irq_o", irq_o, 1'b0, 0);
      foreach (vec_q[i]) begin
        run_vector(vec_q[i]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Budget scales with the number of transactions
  initial begin : watchdog
    wait (load_done);
    repeat ((vec_q.size() + 10) * 200) @(posedge clk_i);
    $display("Timeout: the transaction sequence did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/i3c_csr_top.sv */
// Top level: AXI4-Lite adapter, request router, register file and loopback queue
`default_nettype none

`include "i3c_csr_macros.svh"

module i3c_csr_top
  import i3c_csr_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       rst_i,

  input  wire [`CSR_ADDR_W-1:0]     awaddr_i,
  input  wire                       awvalid_i,
  output logic                      awready_o,
  input  wire [`CSR_DATA_W-1:0]     wdata_i,
  input  wire [`CSR_DATA_W/8-1:0]   wstrb_i,
  input  wire                       wvalid_i,
  output logic                      wready_o,
  output logic [1:0]                bresp_o,
  output logic                      bvalid_o,
  input  wire                       bready_i,

  input  wire [`CSR_ADDR_W-1:0]     araddr_i,
  input  wire                       arvalid_i,
  output logic                      arready_o,
  output logic [`CSR_DATA_W-1:0]    rdata_o,
  output logic [1:0]                rresp_o,
  output logic                      rvalid_o,
  input  wire                       rready_i,

  output hc_ctrl_t                  ctrl_o,
  output logic                      irq_o
);

  cpuif_req_t cpu_req;
  cpuif_rsp_t cpu_rsp;
  cpuif_req_t regs_req;
  cpuif_rsp_t regs_rsp;
  cpuif_req_t queue_req;
  cpuif_rsp_t queue_rsp;
  logic [3:0] rx_thld;
  logic       rx_flush;

  cpuif_axi_lite u_axi (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .req_o     (cpu_req),
    .rsp_i     (cpu_rsp)
  );

  cpuif_mux u_mux (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (cpu_req),
    .rsp_o       (cpu_rsp),
    .regs_req_o  (regs_req),
    .regs_rsp_i  (regs_rsp),
    .queue_req_o (queue_req),
    .queue_rsp_i (queue_rsp)
  );

  csr_regs u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (regs_req),
    .rsp_o      (regs_rsp),
    .ctrl_o     (ctrl_o),
    .rx_thld_o  (rx_thld),
    .rx_flush_o (rx_flush)
  );

  data_port_queue u_queue (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (queue_req),
    .rsp_o      (queue_rsp),
    .rx_thld_i  (rx_thld),
    .rx_flush_i (rx_flush),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

/* verilog/cpuif_mux.sv */
// Address decoder routing cpuif requests to the register file or queue
// and merging their responses
`default_nettype none

`include "i3c_csr_macros.svh"

module cpuif_mux
  import i3c_csr_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire cpuif_req_t   req_i,
  output cpuif_rsp_t        rsp_o,
  output cpuif_req_t        regs_req_o,
  input  wire cpuif_rsp_t   regs_rsp_i,
  output cpuif_req_t        queue_req_o,
  input  wire cpuif_rsp_t   queue_rsp_i
);

  logic sel_regs;
  logic sel_queue;
  logic unmapped_q;

  always_comb begin
    sel_regs  = 1'b0;
    sel_queue = 1'b0;
    case (req_i.addr)
      `ADDR_HC_VERSION, `ADDR_HC_CONTROL, `ADDR_CTRL_DEV_ADDR,
      `ADDR_RESET_CONTROL, `ADDR_QUEUE_THLD_CTRL, `ADDR_SCRATCH: sel_regs = 1'b1;
      `ADDR_TX_DATA_PORT, `ADDR_RX_DATA_PORT, `ADDR_QUEUE_STATUS: sel_queue = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    regs_req_o        = req_i;
    regs_req_o.valid  = req_i.valid && sel_regs;
    queue_req_o       = req_i;
    queue_req_o.valid = req_i.valid && sel_queue;
  end

  // Unmapped access answered here one cycle later
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= req_i.valid && !sel_regs && !sel_queue;
    end
  end

  assign rsp_o.ack     = regs_rsp_i.ack || queue_rsp_i.ack || unmapped_q;
  assign rsp_o.err     = (regs_rsp_i.ack && regs_rsp_i.err) ||
                         (queue_rsp_i.ack && queue_rsp_i.err) || unmapped_q;
  assign rsp_o.rd_data = (regs_rsp_i.ack ? regs_rsp_i.rd_data : '0) |
                         (queue_rsp_i.ack ? queue_rsp_i.rd_data : '0);

  ack_onehot_a : assert property (@(posedge clk_i) disable iff (rst_i)
    !(regs_rsp_i.ack && queue_rsp_i.ack));

endmodule

`default_nettype wire

/* verilog/data_port_queue.sv */
// Loopback FIFO behind the TX and RX data ports,
// queue status register and threshold interrupt
`default_nettype none

`include "i3c_csr_macros.svh"

module data_port_queue
  import i3c_csr_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire cpuif_req_t   req_i,
  output cpuif_rsp_t        rsp_o,
  input  wire [3:0]         rx_thld_i,
  input  wire               rx_flush_i,
  output logic              irq_o
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);

  logic [`CSR_DATA_W-1:0] mem_q [`QUEUE_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [PTR_W:0]         level_q;
  logic                   empty;
  logic                   full;
  logic                   at_thld;
  logic                   push;
  logic                   pop;
  logic                   err_d;
  logic [`CSR_DATA_W-1:0] rd_word;
  logic                   ack_q;
  logic                   err_q;
  logic [`CSR_DATA_W-1:0] rd_data_q;

  assign empty   = (level_q == '0);
  assign full    = (level_q == (PTR_W+1)'(`QUEUE_DEPTH));
  assign at_thld = (rx_thld_i != 4'd0) && (level_q >= rx_thld_i);

  always_comb begin
    push    = 1'b0;
    pop     = 1'b0;
    err_d   = 1'b0;
    rd_word = '0;
    case (req_i.addr)
      `ADDR_TX_DATA_PORT: begin
        push  = req_i.is_wr && !full;
        err_d = !req_i.is_wr || full;
      end
      `ADDR_RX_DATA_PORT: begin
        pop     = !req_i.is_wr && !empty;
        err_d   = req_i.is_wr || empty;
        rd_word = pop ? mem_q[rd_ptr_q] : '0;
      end
      `ADDR_QUEUE_STATUS: begin
        err_d   = req_i.is_wr;
        rd_word = req_i.is_wr ? '0 : {21'b0, at_thld, full, empty, 4'b0, level_q};
      end
      default: err_d = 1'b1;
    endcase
    // Nothing moves unless a request is present
    push  = push && req_i.valid;
    pop   = pop && req_i.valid;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || rx_flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      level_q <= level_q + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i.wr_data;
    end
    rd_data_q <= rd_word;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_i.valid;
      err_q <= req_i.valid && err_d;
    end
  end

  assign rsp_o.ack     = ack_q;
  assign rsp_o.err     = err_q;
  assign rsp_o.rd_data = rd_data_q;
  assign irq_o         = at_thld;

  level_bound_a : assert property (@(posedge clk_i) disable iff (rst_i)
    level_q <= (PTR_W+1)'(`QUEUE_DEPTH));

endmodule

`default_nettype wire

/* verilog/csr_regs.sv */
// Control and status registers with byte strobes,
// self-clearing reset register and read-only version
`default_nettype none

`include "i3c_csr_macros.svh"

module csr_regs
  import i3c_csr_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire cpuif_req_t   req_i,
  output cpuif_rsp_t        rsp_o,
  output hc_ctrl_t          ctrl_o,
  output logic [3:0]        rx_thld_o,
  output logic              rx_flush_o
);

  hc_ctrl_t               ctrl_q;
  logic [3:0]             rx_thld_q;
  logic [`CSR_DATA_W-1:0] scratch_q;
  logic                   rx_flush_q;
  logic                   ack_q;
  logic                   err_q;
  logic [`CSR_DATA_W-1:0] rd_data_q;
  logic [`CSR_DATA_W-1:0] cur_word;
  logic [`CSR_DATA_W-1:0] wr_word;
  logic                   addr_ok;
  logic                   wr_en;
  logic                   soft_rst;

  // Keeps the bytes whose strobe is low
  function automatic logic [`CSR_DATA_W-1:0] merge_strb(
    input logic [`CSR_DATA_W-1:0]   old_v,
    input logic [`CSR_DATA_W-1:0]   new_v,
    input logic [`CSR_DATA_W/8-1:0] strb
  );
    logic [`CSR_DATA_W-1:0] res;
    res = old_v;
    for (int i = 0; i < `CSR_DATA_W/8; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_v[i*8 +: 8];
      end
    end
    return res;
  endfunction

  always_comb begin
    cur_word = '0;
    addr_ok  = 1'b1;
    case (req_i.addr)
      `ADDR_HC_VERSION:      cur_word = `HC_VERSION_VAL;
      `ADDR_HC_CONTROL:      cur_word = {30'b0, ctrl_q.resume, ctrl_q.bus_enable};
      `ADDR_CTRL_DEV_ADDR:   cur_word = {ctrl_q.dyn_addr_valid, 8'b0, ctrl_q.dyn_addr, 16'b0};
      `ADDR_RESET_CONTROL:   cur_word = '0;
      `ADDR_QUEUE_THLD_CTRL: cur_word = {28'b0, rx_thld_q};
      `ADDR_SCRATCH:         cur_word = scratch_q;
      default:               addr_ok  = 1'b0;
    endcase
  end

  assign wr_word  = merge_strb(cur_word, req_i.wr_data, req_i.wr_strb);
  assign wr_en    = req_i.valid && req_i.is_wr;
  assign soft_rst = wr_en && (req_i.addr == `ADDR_RESET_CONTROL) && wr_word[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q     <= '0;
      rx_thld_q  <= '0;
      scratch_q  <= '0;
      rx_flush_q <= 1'b0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      ack_q      <= req_i.valid;
      err_q      <= req_i.valid &&
                    (!addr_ok || (req_i.is_wr && req_i.addr == `ADDR_HC_VERSION));
      rx_flush_q <= wr_en && (req_i.addr == `ADDR_RESET_CONTROL) && wr_word[4];
      if (soft_rst) begin
        ctrl_q    <= '0;
        rx_thld_q <= '0;
        scratch_q <= '0;
      end else if (wr_en) begin
        case (req_i.addr)
          `ADDR_HC_CONTROL: begin
            ctrl_q.bus_enable <= wr_word[0];
            ctrl_q.resume     <= wr_word[1];
          end
          `ADDR_CTRL_DEV_ADDR: begin
            ctrl_q.dyn_addr       <= wr_word[22:16];
            ctrl_q.dyn_addr_valid <= wr_word[31];
          end
          `ADDR_QUEUE_THLD_CTRL: rx_thld_q <= wr_word[3:0];
          `ADDR_SCRATCH:         scratch_q <= wr_word;
          default: ;
        endcase
      end
    end
  end

  // Read data is zero for writes
  always_ff @(posedge clk_i) begin
    rd_data_q <= (req_i.valid && !req_i.is_wr) ? cur_word : '0;
  end

  assign rsp_o.ack     = ack_q;
  assign rsp_o.err     = err_q;
  assign rsp_o.rd_data = rd_data_q;

  assign ctrl_o     = ctrl_q;
  assign rx_thld_o  = rx_thld_q;
  assign rx_flush_o = rx_flush_q;

endmodule

`default_nettype wire

/* verilog/cpuif_axi_lite.sv */
// AXI4-Lite slave adapter to the cpuif request/acknowledge protocol
`default_nettype none

`include "i3c_csr_macros.svh"

module cpuif_axi_lite
  import i3c_csr_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       rst_i,

  input  wire [`CSR_ADDR_W-1:0]     awaddr_i,
  input  wire                       awvalid_i,
  output logic                      awready_o,
  input  wire [`CSR_DATA_W-1:0]     wdata_i,
  input  wire [`CSR_DATA_W/8-1:0]   wstrb_i,
  input  wire                       wvalid_i,
  output logic                      wready_o,
  output logic [1:0]                bresp_o,
  output logic                      bvalid_o,
  input  wire                       bready_i,

  input  wire [`CSR_ADDR_W-1:0]     araddr_i,
  input  wire                       arvalid_i,
  output logic                      arready_o,
  output logic [`CSR_DATA_W-1:0]    rdata_o,
  output logic [1:0]                rresp_o,
  output logic                      rvalid_o,
  input  wire                       rready_i,

  output cpuif_req_t                req_o,
  input  wire cpuif_rsp_t           rsp_i
);

  adapter_state_e             state_q;
  logic                       is_wr_q;
  logic [`CSR_ADDR_W-1:0]     addr_q;
  logic [`CSR_DATA_W-1:0]     wdata_q;
  logic [`CSR_DATA_W/8-1:0]   wstrb_q;
  axi_resp_e                  resp_q;
  logic                       ar_hs;
  logic                       aw_hs;
  logic                       done_hs;
  logic                       rsp_take;

  // Reads win ties, AW and W go in together
  assign arready_o = (state_q == IDLE);
  assign awready_o = (state_q == IDLE) && awvalid_i && wvalid_i && !arvalid_i;
  assign wready_o  = awready_o;

  assign ar_hs    = arvalid_i && arready_o;
  assign aw_hs    = awvalid_i && awready_o;
  assign rsp_take = ((state_q == REQ) || (state_q == WAIT_ACK)) && rsp_i.ack;
  assign done_hs  = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      is_wr_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (ar_hs) begin
            is_wr_q <= 1'b0;
            state_q <= REQ;
          end else if (aw_hs) begin
            is_wr_q <= 1'b1;
            state_q <= REQ;
          end
        end
        REQ, WAIT_ACK: begin
          state_q <= rsp_i.ack ? RESP : WAIT_ACK;
        end
        RESP: begin
          if (done_hs) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Captured transaction and returned response
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q  <= araddr_i;
      wdata_q <= '0;
      wstrb_q <= '0;
    end else if (aw_hs) begin
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (rsp_take) begin
      resp_q <= rsp_i.err ? SLVERR : OKAY;
      if (!is_wr_q) begin
        rdata_o <= rsp_i.rd_data;
      end
    end
  end

  assign req_o.valid   = (state_q == REQ);
  assign req_o.is_wr   = is_wr_q;
  assign req_o.addr    = addr_q;
  assign req_o.wr_data = wdata_q;
  assign req_o.wr_strb = wstrb_q;

  assign bvalid_o = (state_q == RESP) && is_wr_q;
  assign rvalid_o = (state_q == RESP) && !is_wr_q;
  assign bresp_o  = resp_q;
  assign rresp_o  = resp_q;

  rvalid_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

  bvalid_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  // Acks only arrive while a request is outstanding
  ack_in_flight_a : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.ack |-> (state_q == REQ) || (state_q == WAIT_ACK));

endmodule

`default_nettype wire

/* verilog/i3c_csr_pkg.sv */
// Shared types: cpuif request/response, controller settings,
// AXI response codes and adapter states
`default_nettype none

`include "i3c_csr_macros.svh"

package i3c_csr_pkg;

  // One access from the adapter, valid for a single cycle
  typedef struct packed {
    logic                       valid;
    logic                       is_wr;
    logic [`CSR_ADDR_W-1:0]     addr;
    logic [`CSR_DATA_W-1:0]     wr_data;
    logic [`CSR_DATA_W/8-1:0]   wr_strb;
  } cpuif_req_t;

  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`CSR_DATA_W-1:0] rd_data;
  } cpuif_rsp_t;

  // Settings handed to the bus engine
  typedef struct packed {
    logic       bus_enable;
    logic       resume;
    logic       dyn_addr_valid;
    logic [6:0] dyn_addr;
  } hc_ctrl_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK,
    RESP
  } adapter_state_e;

endpackage

`default_nettype wire

/* verilog/i3c_csr_macros.svh */
// Bus widths, queue depth and version value
// Byte offsets of the controller registers and data ports
`ifndef I3C_CSR_MACROS_SVH
`define I3C_CSR_MACROS_SVH

`define CSR_ADDR_W 8
`define CSR_DATA_W 32
`define QUEUE_DEPTH 8

// Reports HCI version 1.2
`define HC_VERSION_VAL 32'h0000_0120

// Register file
`define ADDR_HC_VERSION 8'h00
`define ADDR_HC_CONTROL 8'h04
`define ADDR_CTRL_DEV_ADDR 8'h08
`define ADDR_RESET_CONTROL 8'h0C
`define ADDR_QUEUE_THLD_CTRL 8'h10
`define ADDR_SCRATCH 8'h14

// Loopback data ports
`define ADDR_TX_DATA_PORT 8'h20
`define ADDR_RX_DATA_PORT 8'h24
`define ADDR_QUEUE_STATUS 8'h28

`endif
